// ==== verilog/cong_man_params.svh ====
//////////////////////////////
// Sizing constants for the congestion manager
//////////////////////////////
`ifndef CONG_MAN_PARAMS_SVH
`define CONG_MAN_PARAMS_SVH

// Egress ports and queues
`define CM_NUM_EGR_PORTS 4
`define CM_QUEUES_PER_PORT 2
`define CM_NUM_QUEUES (`CM_NUM_EGR_PORTS * `CM_QUEUES_PER_PORT)

// Buffer geometry
`define CM_DATA_BYTES 64
`define CM_BYTES_PER_PAGE 4096
`define CM_WORDS_PER_PAGE (`CM_BYTES_PER_PAGE / `CM_DATA_BYTES)
`define CM_NUM_PAGES 16

// Packet limits
`define CM_MTU_BYTES 1500

// Marked packets at this priority or higher are kept
`define CM_POLICER_KEEP_PRIO 6

// Default threshold covers the whole buffer
`define CM_THRESH_RESET (`CM_NUM_PAGES * `CM_BYTES_PER_PAGE)

`endif

// ==== verilog/cong_man_pkg.sv ====
//////////////////////////////
// Width types, verdict encoding and the
// descriptor, result and queue state structs
//////////////////////////////
`include "cong_man_params.svh"

package cong_man_pkg;

    typedef logic [$clog2(`CM_NUM_QUEUES)-1:0]     queue_id_t;
    typedef logic [$clog2(`CM_NUM_EGR_PORTS)-1:0]  port_t;
    typedef logic [2:0]                            prio_t;
    typedef logic [$clog2(`CM_MTU_BYTES)-1:0]      byte_len_t;
    typedef logic [31:0]                           occupancy_t;
    typedef logic [31:0]                           thresh_t;
    typedef logic [$clog2(`CM_WORDS_PER_PAGE)-1:0] word_ptr_t;
    typedef logic [$clog2(`CM_NUM_PAGES)-1:0]      page_ptr_t;
    // One extra bit so the count can reach CM_NUM_PAGES
    typedef logic [$clog2(`CM_NUM_PAGES):0]        page_count_t;

    typedef enum logic [2:0] {
        VERDICT_ENQUEUE         = 3'd0,
        VERDICT_DROP_QUEUE_FULL = 3'd1,
        VERDICT_DROP_POLICER    = 3'd2,
        VERDICT_DROP_PAGE_LIMIT = 3'd3,
        VERDICT_DROP_NO_PAGE    = 3'd4
    } verdict_e;

    typedef struct packed {
        port_t     egress_port;
        prio_t     prio;
        byte_len_t byte_length;
        logic      policer_drop_mark;
    } pkt_desc_t;

    typedef struct packed {
        occupancy_t occupancy;
        word_ptr_t  tail_ptr;
        page_ptr_t  page_ptr;
        logic       page_valid;
    } queue_state_t;

    // Occupancy is the value after the decision
    typedef struct packed {
        queue_id_t  queue;
        verdict_e   verdict;
        word_ptr_t  new_tail_ptr;
        logic       malloc_approved;
        page_ptr_t  page_ptr;
        occupancy_t occupancy;
    } admit_result_t;

endpackage

// ==== verilog/drop_thresh_table.sv ====
//////////////////////////////
// Per-queue drop thresholds, Wishbone classic
// config slave plus a lookup read port
//////////////////////////////
`include "cong_man_params.svh"

module drop_thresh_table
    import cong_man_pkg::*;
(
    input  logic      core_clk_ifc,
    input  logic      rst_n,
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  queue_id_t wb_adr,
    input  thresh_t   wb_dat_w,
    output thresh_t   wb_dat_r,
    output logic      wb_ack,
    input  queue_id_t lookup_queue,
    output thresh_t   lookup_thresh
);

    thresh_t thresh_mem [`CM_NUM_QUEUES];
    logic    wb_req;

    // A cycle is new only while no ack is out
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    //////////////////////////////
    // Bus handshake
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (wb_req && !wb_we) begin
            wb_dat_r <= thresh_mem[wb_adr];
        end
    end

    //////////////////////////////
    // Threshold storage
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            for (int q = 0; q < `CM_NUM_QUEUES; q++) begin
                thresh_mem[q] <= thresh_t'(`CM_THRESH_RESET);
            end
        end else if (wb_req && wb_we) begin
            // Lands on the same edge that raises ack
            thresh_mem[wb_adr] <= wb_dat_w;
        end
    end

    // Admission lookup
    assign lookup_thresh = thresh_mem[lookup_queue];

endmodule

// ==== verilog/queue_state_table.sv ====
//////////////////////////////
// Per-queue occupancy, tail and page registers
//////////////////////////////
`include "cong_man_params.svh"

module queue_state_table
    import cong_man_pkg::*;
(
    input  logic         core_clk_ifc,
    input  logic         rst_n,
    input  queue_id_t    rd_queue,
    output queue_state_t rd_state,
    input  logic         wr_en,
    input  queue_id_t    wr_queue,
    input  queue_state_t wr_state
);

    queue_state_t state_mem [`CM_NUM_QUEUES];

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            // Empty queues with no page held
            for (int q = 0; q < `CM_NUM_QUEUES; q++) begin
                state_mem[q].occupancy  <= '0;
                state_mem[q].tail_ptr   <= '0;
                state_mem[q].page_ptr   <= '0;
                state_mem[q].page_valid <= 1'b0;
            end
        end else if (wr_en) begin
            state_mem[wr_queue] <= wr_state;
        end
    end

    // Read straight from the registers
    assign rd_state = state_mem[rd_queue];

endmodule

// ==== verilog/admission_ctrl.sv ====
//////////////////////////////
// Descriptor admission with queue mapping, drop checks,
// page allocation and queue state write-back
//////////////////////////////
`include "cong_man_params.svh"

module admission_ctrl
    import cong_man_pkg::*;
(
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    input  pkt_desc_t     desc,
    input  logic          desc_valid,
    output logic          desc_ready,
    output admit_result_t result,
    output logic          result_valid,
    input  logic          result_ready,
    output queue_id_t     lookup_queue,
    input  thresh_t       thresh,
    input  queue_state_t  state,
    output logic          wr_en,
    output queue_id_t     wr_queue,
    output queue_state_t  wr_state,
    output page_count_t   free_pages
);

    typedef enum logic [1:0] {
        IDLE,
        DECIDE,
        HOLD
    } fsm_e;

    // Priorities 5 to 7 use the second queue of a port
    localparam prio_t HIGH_PRIO  = 3'd5;
    localparam int    LEN_W      = $bits(byte_len_t) + 1;
    localparam int    CNT_W      = $bits(word_ptr_t) + 1;
    localparam int    WORD_SHIFT = $clog2(`CM_DATA_BYTES);
    localparam int    PAGE_SHIFT = $clog2(`CM_BYTES_PER_PAGE);

    fsm_e          fsm;
    pkt_desc_t     desc_q;
    thresh_t       thresh_q;
    queue_state_t  state_q;
    queue_id_t     queue_q;
    page_ptr_t     next_page;
    logic [LEN_W-1:0] len_round;
    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] tail_sum;
    occupancy_t    occ_sum;
    occupancy_t    occ_pages;
    logic          page_needed;
    logic          malloc;
    verdict_e      verdict;
    queue_state_t  new_state;

    function automatic queue_id_t map_queue(pkt_desc_t d);
        logic hi;
        hi = (d.prio >= HIGH_PRIO);
        return queue_id_t'(d.egress_port) * queue_id_t'(`CM_QUEUES_PER_PORT) + queue_id_t'(hi);
    endfunction

    assign lookup_queue = map_queue(desc);
    assign queue_q      = map_queue(desc_q);
    assign desc_ready   = (fsm == IDLE);
    assign result_valid = (fsm == HOLD);

    //////////////////////////////
    // Decision
    //////////////////////////////

    // Packet size in buffer words, rounded up
    assign len_round = {1'b0, desc_q.byte_length} + LEN_W'(`CM_DATA_BYTES - 1);
    assign word_cnt  = CNT_W'(len_round >> WORD_SHIFT);
    assign tail_sum  = {1'b0, state_q.tail_ptr} + word_cnt;
    assign occ_sum   = state_q.occupancy + occupancy_t'(desc_q.byte_length);
    assign occ_pages = state_q.occupancy >> PAGE_SHIFT;

    assign page_needed = !state_q.page_valid || (tail_sum >= CNT_W'(`CM_WORDS_PER_PAGE));

    always_comb begin
        if (occ_sum > thresh_q) begin
            verdict = VERDICT_DROP_QUEUE_FULL;
        end else if (desc_q.policer_drop_mark && desc_q.prio < prio_t'(`CM_POLICER_KEEP_PRIO)) begin
            verdict = VERDICT_DROP_POLICER;
        end else if (page_needed && occ_pages > occupancy_t'(free_pages)) begin
            verdict = VERDICT_DROP_PAGE_LIMIT;
        end else if (page_needed && free_pages == '0) begin
            verdict = VERDICT_DROP_NO_PAGE;
        end else begin
            verdict = VERDICT_ENQUEUE;
        end
    end

    assign malloc = (verdict == VERDICT_ENQUEUE) && page_needed;

    // A drop leaves the queue untouched
    always_comb begin
        new_state = state_q;
        if (verdict == VERDICT_ENQUEUE) begin
            new_state.occupancy = occ_sum;
            new_state.tail_ptr  = word_ptr_t'(tail_sum);
        end
        if (malloc) begin
            new_state.page_ptr   = next_page;
            new_state.page_valid = 1'b1;
        end
    end

    assign wr_en    = (fsm == DECIDE) && (verdict == VERDICT_ENQUEUE);
    assign wr_queue = queue_q;
    assign wr_state = new_state;

    //////////////////////////////
    // Control and allocator
    //////////////////////////////

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            fsm        <= IDLE;
            next_page  <= '0;
            free_pages <= page_count_t'(`CM_NUM_PAGES);
        end else begin
            case (fsm)
                IDLE: begin
                    if (desc_valid) begin
                        fsm <= DECIDE;
                    end
                end
                DECIDE: begin
                    fsm <= HOLD;
                    if (malloc) begin
                        next_page  <= next_page + page_ptr_t'(1);
                        free_pages <= free_pages - page_count_t'(1);
                    end
                end
                HOLD: begin
                    if (result_ready) begin
                        fsm <= IDLE;
                    end
                end
                default: begin
                    fsm <= IDLE;
                end
            endcase
        end
    end

    // Descriptor and table snapshot, then the result
    always_ff @(posedge core_clk_ifc) begin
        if (fsm == IDLE && desc_valid) begin
            desc_q   <= desc;
            thresh_q <= thresh;
            state_q  <= state;
        end
        if (fsm == DECIDE) begin
            result.queue           <= queue_q;
            result.verdict         <= verdict;
            result.new_tail_ptr    <= new_state.tail_ptr;
            result.malloc_approved <= malloc;
            result.page_ptr        <= new_state.page_ptr;
            result.occupancy       <= new_state.occupancy;
        end
    end

endmodule

// ==== verilog/cong_man_top.sv ====
//////////////////////////////
// Congestion manager top level
//////////////////////////////

module cong_man_top
    import cong_man_pkg::*;
(
    input  logic          core_clk_ifc,
    input  logic          rst_n,
    // Descriptor in, result out
    input  pkt_desc_t     desc,
    input  logic          desc_valid,
    output logic          desc_ready,
    output admit_result_t result,
    output logic          result_valid,
    input  logic          result_ready,
    output page_count_t   free_pages,
    // Threshold config bus
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  queue_id_t     wb_adr,
    input  thresh_t       wb_dat_w,
    output thresh_t       wb_dat_r,
    output logic          wb_ack
);

    queue_id_t    lookup_queue;
    thresh_t      lookup_thresh;
    queue_state_t rd_state;
    logic         wr_en;
    queue_id_t    wr_queue;
    queue_state_t wr_state;

    drop_thresh_table u_thresh (
        .core_clk_ifc  (core_clk_ifc),
        .rst_n         (rst_n),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .lookup_queue  (lookup_queue),
        .lookup_thresh (lookup_thresh)
    );

    queue_state_table u_state (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .rd_queue     (lookup_queue),
        .rd_state     (rd_state),
        .wr_en        (wr_en),
        .wr_queue     (wr_queue),
        .wr_state     (wr_state)
    );

    admission_ctrl u_admit (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .desc         (desc),
        .desc_valid   (desc_valid),
        .desc_ready   (desc_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .lookup_queue (lookup_queue),
        .thresh       (lookup_thresh),
        .state        (rd_state),
        .wr_en        (wr_en),
        .wr_queue     (wr_queue),
        .wr_state     (wr_state),
        .free_pages   (free_pages)
    );

endmodule

// ==== verif/cong_man_tb.sv ====
//////////////////////////////
// Trace-driven testbench with clock, reset, Wishbone
// driver, descriptor driver and result checker
//////////////////////////////
`include "cong_man_params.svh"

module cong_man_tb
    import cong_man_pkg::*;
    ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 20;

    logic          core_clk_ifc;
    logic          rst_n;
    pkt_desc_t     desc;
    logic          desc_valid;
    logic          desc_ready;
    admit_result_t result;
    logic          result_valid;
    logic          result_ready;
    page_count_t   free_pages;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    queue_id_t     wb_adr;
    thresh_t       wb_dat_w;
    thresh_t       wb_dat_r;
    logic          wb_ack;

    int   err_count;
    int   fail_count;
    int   pkt_count;
    int   exp_free;
    logic aborted;

    cong_man_top UUT (.*);

    // 100 ns clock
    always #50 core_clk_ifc = ~core_clk_ifc;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("ERR %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
            err_count++;
        end
    endtask

    //////////////////////////////
    // Bus and descriptor drivers
    //////////////////////////////

    // Starts and ends on a falling edge
    task automatic wb_access(input logic we, input queue_id_t adr, input thresh_t wdata,
                             output thresh_t rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        @(negedge core_clk_ifc);
        while (!wb_ack && waited < WAIT_LIMIT) begin
            @(negedge core_clk_ifc);
            waited++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            $display("Timeout: Wishbone access to queue %0d was never acknowledged", adr);
            fail_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic run_packet(input pkt_desc_t pkt, input admit_result_t expd);
        int            waited;
        int            latency;
        int            gap;
        admit_result_t held;
        desc       = pkt;
        desc_valid = 1'b1;
        waited     = 0;
        while (!desc_ready && waited < WAIT_LIMIT) begin
            @(negedge core_clk_ifc);
            waited++;
        end
        if (!desc_ready) begin
            $display("Timeout: descriptor %0d was never accepted", pkt_count);
            fail_count++;
            aborted    = 1'b1;
            desc_valid = 1'b0;
            return;
        end
        // Accept edge falls inside this cycle
        @(negedge core_clk_ifc);
        desc_valid = 1'b0;
        latency    = 1;
        while (!result_valid && latency < WAIT_LIMIT) begin
            check_value("desc_ready", desc_ready, 1'b0);
            @(negedge core_clk_ifc);
            latency++;
        end
        if (!result_valid) begin
            $display("Timeout: no result for descriptor %0d", pkt_count);
            fail_count++;
            aborted = 1'b1;
            return;
        end
        check_value("result latency", latency, 2);
        check_value("result.queue", result.queue, expd.queue);
        check_value("result.verdict", result.verdict, expd.verdict);
        check_value("result.new_tail_ptr", result.new_tail_ptr, expd.new_tail_ptr);
        check_value("result.malloc_approved", result.malloc_approved, expd.malloc_approved);
        check_value("result.page_ptr", result.page_ptr, expd.page_ptr);
        check_value("result.occupancy", result.occupancy, expd.occupancy);
        if (expd.malloc_approved) begin
            exp_free--;
        end
        check_value("free_pages", free_pages, exp_free);
        // Result must hold under back-pressure
        held = result;
        gap  = $urandom % 4;
        repeat (gap) begin
            @(negedge core_clk_ifc);
            check_value("result_valid", result_valid, 1'b1);
            check_value("desc_ready", desc_ready, 1'b0);
            check_value("result", result, held);
        end
        result_ready = 1'b1;
        @(negedge core_clk_ifc);
        result_ready = 1'b0;
        check_value("desc_ready", desc_ready, 1'b1);
        pkt_count++;
    endtask

    //////////////////////////////
    // Trace player
    //////////////////////////////

    initial begin
        int               fd;
        int               code;
        int               rnd;
        int               a_queue;
        int               f [10];
        logic [7:0]       cmd;
        logic [8*128-1:0] line_buf;
        thresh_t          val;
        thresh_t          rdata;
        pkt_desc_t        pkt;
        admit_result_t    expd;
        core_clk_ifc = 1'b0;
        rst_n        = 1'b0;
        desc         = '0;
        desc_valid   = 1'b0;
        result_ready = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        err_count    = 0;
        fail_count   = 0;
        pkt_count    = 0;
        exp_free     = `CM_NUM_PAGES;
        aborted      = 1'b0;
        rnd          = $urandom(72421);
        repeat (5) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        rst_n = 1'b1;
        fd = $fopen("verif/cong_man_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            fail_count++;
            aborted = 1'b1;
        end
        while (!aborted) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                break;
            end
            case (cmd)
                "#": code = $fgets(line_buf, fd);
                "T": begin
                    code = $fscanf(fd, "%d %h", a_queue, val);
                    if (code == 2) begin
                        wb_access(1'b1, queue_id_t'(a_queue), val, rdata);
                    end else begin
                        $display("A threshold write line in the trace has missing fields");
                        fail_count++;
                        aborted = 1'b1;
                    end
                end
                "R": begin
                    code = $fscanf(fd, "%d %h", a_queue, val);
                    if (code == 2) begin
                        wb_access(1'b0, queue_id_t'(a_queue), '0, rdata);
                        check_value("wb_dat_r", rdata, val);
                    end else begin
                        $display("A threshold read line in the trace has missing fields");
                        fail_count++;
                        aborted = 1'b1;
                    end
                end
                "P": begin
                    code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                                   f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (code != 10) begin
                        $display("A packet line in the trace has missing fields");
                        fail_count++;
                        aborted = 1'b1;
                    end else begin
                        pkt.egress_port        = port_t'(f[0]);
                        pkt.prio               = prio_t'(f[1]);
                        pkt.byte_length        = byte_len_t'(f[2]);
                        pkt.policer_drop_mark  = f[3][0];
                        expd.queue             = queue_id_t'(f[4]);
                        expd.verdict           = verdict_e'(f[5]);
                        expd.new_tail_ptr      = word_ptr_t'(f[6]);
                        expd.malloc_approved   = f[7][0];
                        expd.page_ptr          = page_ptr_t'(f[8]);
                        expd.occupancy         = occupancy_t'(f[9]);
                        run_packet(pkt, expd);
                    end
                end
                default: begin
                    $display("Unknown command %c in the trace", cmd);
                    fail_count++;
                    code = $fgets(line_buf, fd);
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Checked %0d packets: %0d value errors, %0d other failures",
                 pkt_count, err_count, fail_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/cong_man_trace.txt ====
# T queue value_hex | R queue expected_hex
# P port prio length mark | expected queue verdict tail malloc page occupancy (decimal)
R 0 10000
R 7 10000
T 0 17fd
T 1 ffe
R 0 17fd
R 1 ffe
# Threshold edge on queues 0 and 1
P 0 0 2047 0 0 0 32 1 0 2047
P 0 3 2047 0 0 0 0 1 1 4094
P 0 4 2047 0 0 0 32 0 1 6141
P 0 1 1 0 0 1 32 0 1 6141
P 0 5 2047 0 1 0 32 1 2 2047
P 0 7 2047 0 1 0 0 1 3 4094
P 0 6 1 0 1 1 0 0 3 4094
# Policer marks
P 1 5 100 1 3 2 0 0 0 0
P 1 6 2047 1 3 0 32 1 4 2047
P 1 0 64 1 2 2 0 0 0 0
# Use up the remaining pages
P 1 0 2047 0 2 0 32 1 5 2047
P 1 1 2047 0 2 0 0 1 6 4094
P 2 0 2047 0 4 0 32 1 7 2047
P 2 3 2047 0 4 0 0 1 8 4094
P 2 5 2047 0 5 0 32 1 9 2047
P 2 6 2047 0 5 0 0 1 10 4094
P 3 0 2047 0 6 0 32 1 11 2047
P 3 2 2047 0 6 0 0 1 12 4094
P 3 5 2047 0 7 0 32 1 13 2047
P 3 7 2047 0 7 0 0 1 14 4094
P 2 1 2047 0 4 0 32 0 8 6141
P 2 2 2047 0 4 0 0 1 15 8188
# Buffer out of pages
T 0 10000
P 0 0 2047 0 0 3 32 0 1 6141
P 1 6 2047 0 3 4 32 0 4 2047
P 2 5 64 0 5 0 1 0 10 4158

// ==== verilog.f ====
+incdir+verilog
verilog/cong_man_pkg.sv
verilog/drop_thresh_table.sv
verilog/queue_state_table.sv
verilog/admission_ctrl.sv
verilog/cong_man_top.sv
verif/cong_man_tb.sv
